/* dbg_params.svh */
`ifndef DBG_PARAMS_SVH
`define DBG_PARAMS_SVH

// identity words returned by local reads of addresses 0 and 1
`define DBG_MODID        16'h0003
`define DBG_VERSION      16'h0001

// buffer depths
`define DBG_IN_DEPTH     4   // request flits
`define DBG_RESP_DEPTH   2   // queued responses

// external register port
`define DBG_REG_TIMEOUT  16  // cycles allowed for ack or err
`define DBG_LOCAL_LIMIT  512 // lowest address handled outside

`endif

/* dbg_pkg.sv */
`default_nettype none

package dbg_pkg;

   // one flit of the debug packet channel
   typedef struct packed {
      logic [15:0] data;
      logic        last;
   } dbg_flit_t;

   // response waiting for the packer
   typedef struct packed {
      logic [9:0]  dest;  // source of the request
      logic        write;
      logic        error;
      logic [15:0] value; // read data, unused for writes and errors
   } dbg_resp_t;

   // local register map
   localparam logic [15:0] REG_MODID   = 16'd0;
   localparam logic [15:0] REG_VERSION = 16'd1;
   localparam logic [15:0] REG_CS      = 16'd3;

   // control/status command, bits 15:11 of the written word
   localparam logic [4:0] CS_CMD_STALL = 5'd1;

endpackage

`default_nettype wire

/* dbg_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module dbg_fifo #(
   parameter type payload_t = logic [15:0],
   parameter int  DEPTH     = 4
) (
   input  wire logic     clk,
   input  wire logic     rst,
   input  wire logic     wr_valid,
   output logic          wr_ready,
   input  wire payload_t wr_data,
   output logic          rd_valid,
   input  wire logic     rd_ready,
   output payload_t      rd_data
);

   localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   payload_t      mem [DEPTH];
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [CW-1:0] count;
   logic          push;
   logic          pop;

   // wrap explicitly, depth need not be a power of two
   function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
      return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign wr_ready = (count != CW'(DEPTH));
   assign rd_valid = (count != '0);
   assign push     = wr_valid && wr_ready;
   assign pop      = rd_valid && rd_ready;
   assign rd_data  = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= next_ptr(wr_ptr);
         if (pop)
            rd_ptr <= next_ptr(rd_ptr);
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count; // idle or push with pop
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= wr_data;
   end

endmodule

`default_nettype wire

/* dbg_reg_timer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dbg_params.svh"

module dbg_reg_timer (
   input  wire logic clk,
   input  wire logic rst,
   input  wire logic start,
   input  wire logic run,
   output logic      expired
);

   localparam int CW = $clog2(`DBG_REG_TIMEOUT + 1);

   logic [CW-1:0] count;

   always_ff @(posedge clk) begin
      if (rst) begin
         count <= '0;
      end else if (start) begin
         count <= CW'(`DBG_REG_TIMEOUT);
      end else if (run && count != '0) begin
         count <= count - 1'b1;
      end
   end

   // the count reaches zero at the end of the last allowed cycle
   assign expired = run && (count <= CW'(1));

endmodule

`default_nettype wire

/* dbg_req_fsm.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dbg_params.svh"

module dbg_req_fsm
   import dbg_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        rst,
   input  wire logic [9:0]  id,
   input  wire logic        rd_valid,
   output logic             rd_ready,
   input  wire dbg_flit_t   rd_data,
   output logic             resp_valid,
   input  wire logic        resp_ready,
   output dbg_resp_t        resp_data,
   output logic             reg_request,
   output logic             reg_write,
   output logic [15:0]      reg_addr,
   output logic [15:0]      reg_wdata,
   input  wire logic        reg_ack,
   input  wire logic        reg_err,
   input  wire logic [15:0] reg_rdata,
   output logic             tmr_start,
   output logic             tmr_run,
   input  wire logic        tmr_expired,
   output logic             stall
);

   localparam logic [1:0] SIZE_16 = 2'b01;

   typedef enum logic [2:0] {
      S_IDLE,
      S_HEADER,
      S_ADDRESS,
      S_WDATA,
      S_EXTERNAL,
      S_DROP,
      S_RESPOND
   } state_t;

   state_t      state;
   state_t      nxt_state;
   logic        stall_q;
   logic        nxt_stall;
   logic        silent;     // drop without answering
   logic        nxt_silent;
   logic        req_write;
   logic        nxt_write;
   logic        req_burst;
   logic        nxt_burst;
   logic [1:0]  req_size;
   logic [1:0]  nxt_size;
   logic [15:0] req_addr;
   logic [15:0] nxt_addr;
   logic [15:0] req_value;  // write data, then read data
   logic [15:0] nxt_value;
   logic [9:0]  resp_dest;
   logic [9:0]  nxt_dest;
   logic        resp_error;
   logic        nxt_error;
   logic        bad_access;
   logic        flit_ext;
   logic        req_ext;

   assign bad_access = req_burst || (req_size != SIZE_16);
   assign flit_ext   = (rd_data.data >= 16'(`DBG_LOCAL_LIMIT));
   assign req_ext    = (req_addr >= 16'(`DBG_LOCAL_LIMIT));

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= S_IDLE;
         stall_q   <= 1'b0;
         silent    <= 1'b0;
         resp_dest <= id; // points home until the first header
      end else begin
         state     <= nxt_state;
         stall_q   <= nxt_stall;
         silent    <= nxt_silent;
         resp_dest <= nxt_dest;
      end
      req_write  <= nxt_write;
      req_burst  <= nxt_burst;
      req_size   <= nxt_size;
      req_addr   <= nxt_addr;
      req_value  <= nxt_value;
      resp_error <= nxt_error;
   end

   always_comb begin
      nxt_state  = state;
      nxt_stall  = stall_q;
      nxt_silent = silent;
      nxt_write  = req_write;
      nxt_burst  = req_burst;
      nxt_size   = req_size;
      nxt_addr   = req_addr;
      nxt_value  = req_value;
      nxt_dest   = resp_dest;
      nxt_error  = resp_error;
      rd_ready   = 1'b0;
      resp_valid = 1'b0;
      tmr_start  = 1'b0;
      tmr_run    = 1'b0;

      case (state)
         S_IDLE: begin
            rd_ready = 1'b1;
            // destination flit, a packet of one flit has no source to answer
            if (rd_valid && !rd_data.last)
               nxt_state = S_HEADER;
         end
         S_HEADER: begin
            rd_ready = 1'b1;
            if (rd_valid) begin
               nxt_write  = rd_data.data[12];
               nxt_burst  = rd_data.data[13];
               nxt_size   = rd_data.data[11:10];
               nxt_dest   = rd_data.data[9:0];
               nxt_error  = 1'b0;
               nxt_silent = |rd_data.data[15:14];
               if (|rd_data.data[15:14]) begin
                  nxt_state = rd_data.last ? S_IDLE : S_DROP;
               end else if (rd_data.last) begin
                  nxt_error = 1'b1; // no address
                  nxt_state = S_RESPOND;
               end else begin
                  nxt_state = S_ADDRESS;
               end
            end
         end
         S_ADDRESS: begin
            rd_ready = 1'b1;
            if (rd_valid) begin
               nxt_addr = rd_data.data;
               if (bad_access) begin
                  nxt_error = 1'b1;
                  nxt_state = rd_data.last ? S_RESPOND : S_DROP;
               end else if (req_write) begin
                  nxt_error = rd_data.last; // write without data
                  nxt_state = rd_data.last ? S_RESPOND : S_WDATA;
               end else if (!rd_data.last) begin
                  nxt_error = 1'b1;
                  nxt_state = S_DROP;
               end else if (flit_ext) begin
                  tmr_start = 1'b1;
                  nxt_state = S_EXTERNAL;
               end else begin
                  case (rd_data.data)
                     REG_MODID:   nxt_value = `DBG_MODID;
                     REG_VERSION: nxt_value = `DBG_VERSION;
                     default:     nxt_error = 1'b1;
                  endcase
                  nxt_state = S_RESPOND;
               end
            end
         end
         S_WDATA: begin
            rd_ready = 1'b1;
            if (rd_valid) begin
               nxt_value = rd_data.data;
               if (!rd_data.last) begin
                  nxt_error = 1'b1; // overlong, no side effect
                  nxt_state = S_DROP;
               end else if (req_ext) begin
                  tmr_start = 1'b1;
                  nxt_state = S_EXTERNAL;
               end else begin
                  if (req_addr == REG_CS && rd_data.data[15:11] == CS_CMD_STALL)
                     nxt_stall = rd_data.data[0];
                  else
                     nxt_error = 1'b1; // read-only, unknown register or command
                  nxt_state = S_RESPOND;
               end
            end
         end
         S_EXTERNAL: begin
            tmr_run = 1'b1;
            if (reg_ack || reg_err) begin
               if (!req_write)
                  nxt_value = reg_rdata;
               nxt_error = reg_err;
               nxt_state = S_RESPOND;
            end else if (tmr_expired) begin
               nxt_error = 1'b1;
               nxt_state = S_RESPOND;
            end
         end
         S_DROP: begin
            rd_ready = 1'b1;
            if (rd_valid && rd_data.last)
               nxt_state = silent ? S_IDLE : S_RESPOND;
         end
         S_RESPOND: begin
            resp_valid = 1'b1;
            if (resp_ready)
               nxt_state = S_IDLE;
         end
         default: nxt_state = S_IDLE;
      endcase
   end

   assign reg_request = (state == S_EXTERNAL);
   assign reg_write   = req_write;
   assign reg_addr    = req_addr;
   assign reg_wdata   = req_value;
   assign stall       = stall_q;

   assign resp_data = '{dest: resp_dest, write: req_write, error: resp_error, value: req_value};

endmodule

`default_nettype wire

/* dbg_resp_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module dbg_resp_packer
   import dbg_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       rst,
   input  wire logic [9:0] id,
   input  wire logic       resp_valid,
   output logic            resp_ready,
   input  wire dbg_resp_t  resp_data,
   output logic            out_valid,
   input  wire logic       out_ready,
   output logic [15:0]     out_data,
   output logic            out_last
);

   logic [1:0] phase; // 0 dest, 1 status, 2 value
   logic       has_value;
   logic       flit_done;

   // only a good read carries a value flit
   assign has_value = !resp_data.write && !resp_data.error;
   assign out_valid = resp_valid;
   assign flit_done = out_valid && out_ready;

   always_comb begin
      case (phase)
         2'd0: begin
            out_data = {6'h00, resp_data.dest};
            out_last = 1'b0;
         end
         2'd1: begin
            out_data = {4'h0, resp_data.write, resp_data.error, id};
            out_last = !has_value;
         end
         default: begin
            out_data = resp_data.value;
            out_last = 1'b1;
         end
      endcase
   end

   assign resp_ready = flit_done && out_last; // pop with the final flit

   always_ff @(posedge clk) begin
      if (rst) begin
         phase <= 2'd0;
      end else if (flit_done) begin
         phase <= out_last ? 2'd0 : phase + 2'd1;
      end
   end

endmodule

`default_nettype wire

/* dbg_regaccess_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dbg_params.svh"

module dbg_regaccess_top
   import dbg_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        rst,
   input  wire logic [9:0]  id,
   input  wire logic        in_valid,
   output logic             in_ready,
   input  wire logic [15:0] in_data,
   input  wire logic        in_last,
   output logic             out_valid,
   input  wire logic        out_ready,
   output logic [15:0]      out_data,
   output logic             out_last,
   output logic             reg_request,
   output logic             reg_write,
   output logic [15:0]      reg_addr,
   output logic [15:0]      reg_wdata,
   input  wire logic        reg_ack,
   input  wire logic        reg_err,
   input  wire logic [15:0] reg_rdata,
   output logic             stall
);

   dbg_flit_t in_flit;
   dbg_flit_t req_flit;
   logic      req_valid;
   logic      req_ready;
   dbg_resp_t fsm_resp;
   logic      fsm_resp_valid;
   logic      fsm_resp_ready;
   dbg_resp_t q_resp;
   logic      q_resp_valid;
   logic      q_resp_ready;
   logic      tmr_start;
   logic      tmr_run;
   logic      tmr_expired;

   assign in_flit = '{data: in_data, last: in_last};

   dbg_fifo #(
      .payload_t (dbg_flit_t),
      .DEPTH     (`DBG_IN_DEPTH)
   ) in_fifo (
      .clk      (clk),
      .rst      (rst),
      .wr_valid (in_valid),
      .wr_ready (in_ready),
      .wr_data  (in_flit),
      .rd_valid (req_valid),
      .rd_ready (req_ready),
      .rd_data  (req_flit)
   );

   dbg_req_fsm req_fsm (
      .clk         (clk),
      .rst         (rst),
      .id          (id),
      .rd_valid    (req_valid),
      .rd_ready    (req_ready),
      .rd_data     (req_flit),
      .resp_valid  (fsm_resp_valid),
      .resp_ready  (fsm_resp_ready),
      .resp_data   (fsm_resp),
      .reg_request (reg_request),
      .reg_write   (reg_write),
      .reg_addr    (reg_addr),
      .reg_wdata   (reg_wdata),
      .reg_ack     (reg_ack),
      .reg_err     (reg_err),
      .reg_rdata   (reg_rdata),
      .tmr_start   (tmr_start),
      .tmr_run     (tmr_run),
      .tmr_expired (tmr_expired),
      .stall       (stall)
   );

   dbg_reg_timer reg_timer (
      .clk     (clk),
      .rst     (rst),
      .start   (tmr_start),
      .run     (tmr_run),
      .expired (tmr_expired)
   );

   dbg_fifo #(
      .payload_t (dbg_resp_t),
      .DEPTH     (`DBG_RESP_DEPTH)
   ) resp_fifo (
      .clk      (clk),
      .rst      (rst),
      .wr_valid (fsm_resp_valid),
      .wr_ready (fsm_resp_ready),
      .wr_data  (fsm_resp),
      .rd_valid (q_resp_valid),
      .rd_ready (q_resp_ready),
      .rd_data  (q_resp)
   );

   dbg_resp_packer resp_packer (
      .clk        (clk),
      .rst        (rst),
      .id         (id),
      .resp_valid (q_resp_valid),
      .resp_ready (q_resp_ready),
      .resp_data  (q_resp),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_data   (out_data),
      .out_last   (out_last)
   );

endmodule

`default_nettype wire

/* dbg_regaccess_assert.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dbg_params.svh"

module dbg_regaccess_assert (
   input wire logic        clk,
   input wire logic        rst,
   input wire logic        out_valid,
   input wire logic        out_ready,
   input wire logic [15:0] out_data,
   input wire logic        out_last,
   input wire logic        reg_request,
   input wire logic        reg_write,
   input wire logic [15:0] reg_addr,
   input wire logic [15:0] reg_wdata,
   input wire logic        reg_ack,
   input wire logic        reg_err,
   input wire logic        tmr_expired,
   input wire logic        stall
);

   int fail_count = 0;
   int req_cycles;  // length of the current register request

   always_ff @(posedge clk) begin
      if (rst || !reg_request)
         req_cycles <= 0;
      else
         req_cycles <= req_cycles + 1;
   end

   out_hold: assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
      else begin
         fail_count++;
         $error("output flit changed while out_ready was low");
      end

   req_hold: assert property (@(posedge clk) disable iff (rst)
      reg_request && !reg_ack && !reg_err && !tmr_expired |=>
         reg_request && $stable(reg_addr) && $stable(reg_write) && $stable(reg_wdata))
      else begin
         fail_count++;
         $error("register request changed before acknowledge");
      end

   stall_rst: assert property (@(posedge clk) rst |=> !stall)
      else begin
         fail_count++;
         $error("stall high after reset");
      end

   req_limit: assert property (@(posedge clk) disable iff (rst)
      reg_request |-> req_cycles < `DBG_REG_TIMEOUT)
      else begin
         fail_count++;
         $error("register request outlasted the timeout");
      end

endmodule

bind dbg_regaccess_top dbg_regaccess_assert dbg_assert0 (
   .clk         (clk),
   .rst         (rst),
   .out_valid   (out_valid),
   .out_ready   (out_ready),
   .out_data    (out_data),
   .out_last    (out_last),
   .reg_request (reg_request),
   .reg_write   (reg_write),
   .reg_addr    (reg_addr),
   .reg_wdata   (reg_wdata),
   .reg_ack     (reg_ack),
   .reg_err     (reg_err),
   .tmr_expired (tmr_expired),
   .stall       (stall)
);

`default_nettype wire

/* dbg_regaccess_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dbg_params.svh"

module dbg_regaccess_tb
   import dbg_pkg::*;
();

   localparam logic [9:0] EP_ID = 10'h2a5;

   logic        clk;
   logic        rst;
   logic        in_valid;
   logic        in_ready;
   logic [15:0] in_data;
   logic        in_last;
   logic        out_valid;
   logic        out_ready;
   logic [15:0] out_data;
   logic        out_last;
   logic        reg_request;
   logic        reg_write;
   logic [15:0] reg_addr;
   logic [15:0] reg_wdata;
   logic        reg_ack;
   logic        reg_err;
   logic [15:0] reg_rdata;
   logic        stall;

   logic [31:0] lfsr = 32'h8e48;
   logic        random_mode = 1'b0;  // input gaps and random out_ready
   logic [15:0] pkt [$];             // request being sent
   logic [16:0] exp_q [$];           // {last, data} of expected flits
   logic [15:0] slave_mem [64];
   logic [15:0] ref_mem [64];
   logic        ref_stall = 1'b0;
   int          errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;

   dbg_regaccess_top dut0 (
      .clk (clk), .rst (rst), .id (EP_ID),
      .in_valid (in_valid), .in_ready (in_ready), .in_data (in_data), .in_last (in_last),
      .out_valid (out_valid), .out_ready (out_ready), .out_data (out_data),
      .out_last (out_last),
      .reg_request (reg_request), .reg_write (reg_write), .reg_addr (reg_addr),
      .reg_wdata (reg_wdata), .reg_ack (reg_ack), .reg_err (reg_err),
      .reg_rdata (reg_rdata), .stall (stall)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // galois lfsr, one step per bit
   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] r;
      int          i;
      r = '0;
      for (i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
         r = {r[14:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic logic [15:0] fill_value(input logic [15:0] addr);
      return 16'(addr * 16'h0f35) ^ 16'h9c6a;
   endfunction

   function automatic logic [15:0] header_word(input logic [1:0] typ, input logic burst,
                                               input logic wr, input logic [1:0] size,
                                               input logic [9:0] src);
      return {typ, burst, wr, size, src};
   endfunction

   // expected response flits for pkt, updates the reference state
   function automatic void expected_response();
      logic [15:0] hdr;
      logic [15:0] addr;
      logic [15:0] data;
      logic        wr;
      logic        err;
      logic [15:0] value;
      hdr   = pkt[1];
      addr  = (pkt.size() > 2) ? pkt[2] : 16'h0;
      data  = (pkt.size() > 3) ? pkt[3] : 16'h0;
      wr    = hdr[12];
      err   = 1'b0;
      value = 16'h0;
      if (hdr[15:14] != 2'd0)
         return;  // dropped, no answer
      if (pkt.size() != (wr ? 4 : 3) || hdr[13] || hdr[11:10] != 2'd1) begin
         err = 1'b1;
      end else if (addr >= 16'd768) begin
         err = 1'b1;  // error slave or silent
      end else if (addr >= 16'(`DBG_LOCAL_LIMIT)) begin
         if (wr)
            ref_mem[addr[5:0]] = data;
         else
            value = ref_mem[addr[5:0]];
      end else if (wr) begin
         if (addr == REG_CS && data[15:11] == CS_CMD_STALL)
            ref_stall = data[0];
         else
            err = 1'b1;
      end else if (addr == REG_MODID) begin
         value = `DBG_MODID;
      end else if (addr == REG_VERSION) begin
         value = `DBG_VERSION;
      end else begin
         err = 1'b1;
      end
      exp_q.push_back({1'b0, 6'h00, hdr[9:0]});
      exp_q.push_back({wr || err, 4'h0, wr, err, EP_ID});
      if (!wr && !err)
         exp_q.push_back({1'b1, value});
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAIL t=%0t %s: got %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic send_packet();
      int i;
      int waits;
      for (i = 0; i < pkt.size(); i++) begin
         if (random_mode && rand_bits(2) == 16'd0) begin
            in_valid = 1'b0;
            @(posedge clk);
            #1;
         end
         in_valid = 1'b1;
         in_data  = pkt[i];
         in_last  = (i == pkt.size() - 1);
         waits    = 0;
         @(negedge clk);
         while (!in_ready && waits < 200) begin
            @(negedge clk);
            waits++;
         end
         if (!in_ready)
            $display("timeout: input channel never accepted flit %0d", i);
         if (!in_ready)
            errors++;
         @(posedge clk);
         #1;
      end
      in_valid = 1'b0;
      in_last  = 1'b0;
   endtask

   // builds a packet of n flits, predicts its answer and sends it
   task automatic request(input logic [15:0] hdr, input logic [15:0] addr,
                          input logic [15:0] data, input int n);
      pkt.delete();
      pkt.push_back(16'h0000);
      pkt.push_back(hdr);
      pkt.push_back(addr);
      pkt.push_back(data);
      while (pkt.size() < n)
         pkt.push_back(16'hbe00 + 16'(pkt.size()));
      while (pkt.size() > n)
         void'(pkt.pop_back());
      expected_response();
      send_packet();
   endtask

   task automatic wait_drain(input int limit);
      int waits;
      waits = 0;
      while (exp_q.size() != 0 && waits < limit) begin
         @(negedge clk);
         waits++;
      end
      if (exp_q.size() != 0) begin
         $display("timeout: %0d response flits never arrived", exp_q.size());
         errors++;
         exp_q.delete();
      end
      repeat (4) @(posedge clk);  // catches stray flits
      #1;
   endtask

   task automatic finish_test(input string name, input int errs_before);
      tests_run++;
      if (errors == errs_before) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - errs_before);
      end
   endtask

   // compare every accepted output flit
   always @(negedge clk) begin
      if (!rst && out_valid && out_ready) begin
         if (exp_q.size() == 0) begin
            $display("unexpected output flit %h at %0t", out_data, $time);
            errors++;
         end else begin
            check_value("out_flit", {15'h0, out_last, out_data}, {15'h0, exp_q.pop_front()});
         end
      end
   end

   initial begin
      out_ready = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         out_ready = random_mode ? rand_bits(1) != 16'd0 : 1'b1;
      end
   end

   // register slave: 512..767 memory, 768..1023 error, 1024 and up silent
   initial begin : reg_slave
      int          delay;
      int          waits;
      logic [15:0] a;
      reg_ack   = 1'b0;
      reg_err   = 1'b0;
      reg_rdata = 16'h0;
      forever begin
         @(negedge clk);
         if (reg_request) begin
            a = reg_addr;
            if (a >= 16'd1024) begin
               waits = 0;
               while (reg_request && waits < 40) begin
                  @(negedge clk);
                  waits++;
               end
            end else begin
               delay = int'(rand_bits(3));
               repeat (delay) @(posedge clk);
               @(posedge clk);
               #1;
               if (a >= 16'd768) begin
                  reg_err = 1'b1;
               end else begin
                  reg_ack = 1'b1;
                  if (reg_write)
                     slave_mem[a[5:0]] = reg_wdata;
                  else
                     reg_rdata = slave_mem[a[5:0]];
               end
               @(posedge clk);
               #1;
               reg_ack = 1'b0;
               reg_err = 1'b0;
            end
         end
      end
   end

   initial begin : main
      int          k;
      int          errs;
      int          afails;
      logic [2:0]  kind;
      logic [9:0]  src;
      logic [15:0] a;
      logic [15:0] d;
      rst      = 1'b1;
      in_valid = 1'b0;
      in_data  = 16'h0;
      in_last  = 1'b0;
      for (k = 0; k < 64; k++) begin
         slave_mem[k] = fill_value(16'(`DBG_LOCAL_LIMIT + k));
         ref_mem[k]   = fill_value(16'(`DBG_LOCAL_LIMIT + k));
      end
      repeat (4) @(posedge clk);
      #1 rst = 1'b0;

      errs = errors;
      request(header_word(2'd0, 1'b0, 1'b0, 2'd1, 10'h011), REG_MODID, 16'h0, 3);
      request(header_word(2'd0, 1'b0, 1'b0, 2'd1, 10'h3f0), REG_VERSION, 16'h0, 3);
      wait_drain(500);
      finish_test("local reads", errs);

      errs = errors;
      request(header_word(2'd0, 1'b0, 1'b1, 2'd1, 10'h022), REG_CS, 16'h0801, 4);
      wait_drain(500);
      check_value("stall", stall, 1);
      request(header_word(2'd0, 1'b0, 1'b1, 2'd1, 10'h023), REG_CS, 16'h0800, 4);
      wait_drain(500);
      check_value("stall", stall, 0);
      finish_test("stall control", errs);

      errs = errors;
      request(header_word(2'd0, 1'b0, 1'b1, 2'd1, 10'h031), 16'h0205, 16'h1234, 4);
      request(header_word(2'd0, 1'b0, 1'b0, 2'd1, 10'h032), 16'h0205, 16'h0, 3);
      request(header_word(2'd0, 1'b0, 1'b1, 2'd1, 10'h033), 16'h023f, 16'hcafe, 4);
      request(header_word(2'd0, 1'b0, 1'b0, 2'd1, 10'h034), 16'h023f, 16'h0, 3);
      request(header_word(2'd0, 1'b0, 1'b0, 2'd1, 10'h035), 16'h0300, 16'h0, 3);
      wait_drain(500);
      finish_test("external access", errs);

      errs = errors;
      request(header_word(2'd0, 1'b0, 1'b0, 2'd1, 10'h041), 16'h0400, 16'h0, 3);
      wait_drain(500);
      check_value("reg_request", reg_request, 0);
      finish_test("silent address", errs);

      errs = errors;
      request(header_word(2'd0, 1'b0, 1'b1, 2'd1, 10'h100), REG_CS, 16'h0801, 4);
      request(header_word(2'd0, 1'b0, 1'b0, 2'd1, 10'h101), 16'h0002, 16'h0, 3);
      request(header_word(2'd0, 1'b0, 1'b0, 2'd2, 10'h102), REG_MODID, 16'h0, 3);
      request(header_word(2'd0, 1'b1, 1'b0, 2'd1, 10'h103), REG_MODID, 16'h0, 3);
      request(header_word(2'd0, 1'b0, 1'b1, 2'd1, 10'h104), REG_CS, 16'h0800, 3);
      request(header_word(2'd0, 1'b0, 1'b1, 2'd1, 10'h105), REG_CS, 16'h0800, 5);
      request(header_word(2'd0, 1'b0, 1'b1, 2'd1, 10'h106), REG_MODID, 16'h0800, 4);
      request(header_word(2'd0, 1'b0, 1'b1, 2'd1, 10'h107), REG_CS, 16'h1000, 4);
      request(header_word(2'd1, 1'b0, 1'b0, 2'd1, 10'h108), REG_MODID, 16'h0, 3);
      request(header_word(2'd0, 1'b0, 1'b0, 2'd1, 10'h109), REG_VERSION, 16'h0, 3);
      wait_drain(1000);
      check_value("stall", stall, 1);
      finish_test("error cases", errs);

      errs = errors;
      random_mode = 1'b1;
      for (k = 0; k < 100; k++) begin
         kind = 3'(rand_bits(3));
         src  = 10'(rand_bits(10));
         d    = rand_bits(16);
         a    = 16'(`DBG_LOCAL_LIMIT) + {10'h0, d[5:0]};
         case (kind)
            3'd0: request(header_word(2'd0, 1'b0, 1'b0, 2'd1, src), d & 16'h0003, 16'h0, 3);
            3'd1: request(header_word(2'd0, 1'b0, 1'b1, 2'd1, src), REG_CS,
                          {(d[10] ? CS_CMD_STALL : d[15:11]), d[10:0]}, 4);
            3'd2, 3'd3: request(header_word(2'd0, 1'b0, 1'b0, 2'd1, src), a, 16'h0, 3);
            3'd4, 3'd6: request(header_word(2'd0, 1'b0, 1'b1, 2'd1, src), a, d, 4);
            3'd5: request(header_word(2'd0, 1'b0, d[5], 2'd1, src),
                          (d[9:6] == 4'd0 ? 16'd1024 : 16'd768) + {12'h0, d[3:0]},
                          d, d[5] ? 4 : 3);
            default: request(header_word((d[15:13] == 3'd0) ? 2'd2 : 2'd0, d[12], d[11],
                                         d[9:8], src), a, d, 2 + int'(d[7:6]));
         endcase
      end
      wait_drain(20000);
      random_mode = 1'b0;
      check_value("stall", stall, ref_stall);
      finish_test("random traffic", errs);

      afails = dut0.dbg_assert0.fail_count;
      $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
               tests_run, tests_failed, errors, afails);
      if (errors == 0 && afails == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* dbg_regaccess_top.f */
+incdir+.
dbg_pkg.sv
dbg_fifo.sv
dbg_reg_timer.sv
dbg_req_fsm.sv
dbg_resp_packer.sv
dbg_regaccess_top.sv
dbg_regaccess_assert.sv
dbg_regaccess_tb.sv

/* Makefile */
SIM := obj_dir/Vdbg_regaccess_tb

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): dbg_regaccess_top.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module dbg_regaccess_tb -f dbg_regaccess_top.f

run: $(SIM)
	@out="$$(./$(SIM) +verilator+error+limit+1000)"; \
		echo "$$out"; \
		echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
